//--- rtl/mt_core_pkg.sv
`default_nettype none

package mt_core_pkg;

	// ============================================================
	// Core dimensions
	// ============================================================

	localparam int NTHREADS = 4;
	localparam int THREAD_W = 2;
	localparam int NREGS = 16;
	localparam int REG_W = 4;
	localparam int DATA_W = 32;

	typedef logic [THREAD_W-1:0] thread_id_t;
	typedef logic [REG_W-1:0] reg_num_t;
	typedef logic [DATA_W-1:0] value_t;

	// ============================================================
	// Decoded instruction format
	// ============================================================

	// Shift amounts come from the low five bits of rb
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND_OP,
		OR_OP,
		XOR_OP,
		SHL,
		SHR,
		ADDI
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		reg_num_t rt;
		reg_num_t ra;
		reg_num_t rb;
		logic [15:0] imm;
	} insn_t;

	// Core input word, the instruction tagged with its thread
	typedef struct packed {
		thread_id_t thread;
		insn_t insn;
	} thread_insn_t;

	// Writeback record, also the commit bus
	typedef struct packed {
		thread_id_t thread;
		reg_num_t rt;
		value_t value;
	} result_t;

endpackage

`default_nettype wire

//--- rtl/insn_queue.sv
`default_nettype none

module insn_queue
	import mt_core_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk_g,
	input wire rst_i,
	input wire push_i,
	input wire insn_t push_insn_i,
	input wire pop_i,
	output insn_t head_o,
	output logic head_valid_o,
	output logic full_o
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	insn_t mem_q [QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	assign head_valid_o = (count_q != '0);
	assign full_o = (count_q == CNT_W'(QUEUE_DEPTH));
	assign head_o = mem_q[rd_ptr_q];

	// A full queue refuses the push even if the head leaves this cycle
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && head_valid_o;

	always_ff @(posedge clk_g) begin
		if (do_push)
			mem_q[wr_ptr_q] <= push_insn_i;
	end

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/round_robin_select.sv
`default_nettype none

module round_robin_select
	import mt_core_pkg::*;
(
	input wire clk_g,
	input wire rst_i,
	input wire [NTHREADS-1:0] req_i,
	output thread_id_t grant_o,
	output logic grant_valid_o
);

	// Thread that has first claim on the next grant
	thread_id_t ptr_q;

	// Scan downward so the closest requester after the pointer wins
	always_comb begin
		int idx;
		grant_o = ptr_q;
		grant_valid_o = 1'b0;
		for (int i = NTHREADS - 1; i >= 0; i--) begin
			idx = (int'(ptr_q) + i) % NTHREADS;
			if (req_i[idx]) begin
				grant_o = thread_id_t'(idx);
				grant_valid_o = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_g) begin
		if (rst_i)
			ptr_q <= '0;
		else if (grant_valid_o)
			ptr_q <= thread_id_t'((int'(grant_o) + 1) % NTHREADS);
	end

endmodule

`default_nettype wire

//--- rtl/scoreboard.sv
`default_nettype none

module scoreboard
	import mt_core_pkg::*;
(
	input wire clk_g,
	input wire rst_i,
	input wire insn_t [NTHREADS-1:0] heads_i,
	input wire [NTHREADS-1:0] head_valid_i,
	input wire stall_i,
	input wire issue_valid_i,
	input wire thread_id_t issue_thread_i,
	input wire reg_num_t issue_rt_i,
	input wire commit_valid_i,
	input wire result_t commit_i,
	output logic [NTHREADS-1:0] issue_req_o
);

	// One bit per register per thread, set while a write is in flight
	logic [NTHREADS-1:0][NREGS-1:0] pending_q;

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			pending_q <= '0;
		end else begin
			if (commit_valid_i)
				pending_q[commit_i.thread][commit_i.rt] <= 1'b0;
			// r0 never holds a value worth waiting for
			if (issue_valid_i && issue_rt_i != '0)
				pending_q[issue_thread_i][issue_rt_i] <= 1'b1;
		end
	end

	// Pending rt also blocks, so one thread never has two writes to a register
	always_comb begin
		for (int t = 0; t < NTHREADS; t++) begin
			issue_req_o[t] = head_valid_i[t] && !stall_i
				&& !pending_q[t][heads_i[t].ra]
				&& !pending_q[t][heads_i[t].rb]
				&& !pending_q[t][heads_i[t].rt];
		end
	end

endmodule

`default_nettype wire

//--- rtl/thread_regfile.sv
`default_nettype none

module thread_regfile
	import mt_core_pkg::*;
(
	input wire clk_g,
	input wire rst_i,
	input wire thread_id_t rd_thread_i,
	input wire reg_num_t ra_i,
	input wire reg_num_t rb_i,
	output value_t a_o,
	output value_t b_o,
	input wire wr_i,
	input wire result_t wr_data_i
);

	// Thread id forms the upper index bits
	value_t regs_q [NTHREADS*NREGS];

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			for (int i = 0; i < NTHREADS * NREGS; i++)
				regs_q[i] <= '0;
		end else if (wr_i && wr_data_i.rt != '0) begin
			regs_q[{wr_data_i.thread, wr_data_i.rt}] <= wr_data_i.value;
		end
	end

	// r0 stays at its reset value since it is never written
	always_ff @(posedge clk_g) begin
		a_o <= regs_q[{rd_thread_i, ra_i}];
		b_o <= regs_q[{rd_thread_i, rb_i}];
	end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`default_nettype none

module int_alu
	import mt_core_pkg::*;
(
	input wire opcode_e op_i,
	input wire value_t a_i,
	input wire value_t b_i,
	input wire [15:0] imm_i,
	output value_t res_o
);

	value_t imm_ext;

	assign imm_ext = {{(DATA_W - 16){imm_i[15]}}, imm_i};

	always_comb begin
		case (op_i)
			ADD: res_o = a_i + b_i;
			SUB: res_o = a_i - b_i;
			AND_OP: res_o = a_i & b_i;
			OR_OP: res_o = a_i | b_i;
			XOR_OP: res_o = a_i ^ b_i;
			SHL: res_o = a_i << b_i[4:0];
			// Logical shift, zeros come in at the top
			SHR: res_o = a_i >> b_i[4:0];
			ADDI: res_o = a_i + imm_ext;
			default: res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/exec_pipeline.sv
`default_nettype none

module exec_pipeline
	import mt_core_pkg::*;
(
	input wire clk_g,
	input wire rst_i,
	input wire issue_valid_i,
	input wire thread_id_t issue_thread_i,
	input wire insn_t issue_insn_i,
	input wire value_t a_i,
	input wire value_t b_i,
	output result_t result_o,
	output logic result_valid_o,
	input wire result_ready_i,
	output logic commit_valid_o,
	output logic stall_o
);

	// ============================================================
	// Register read stage
	// ============================================================
	logic rd_v_q;
	logic rd_fresh_q;
	thread_id_t rd_thread_q;
	insn_t rd_insn_q;
	value_t rd_a_q;
	value_t rd_b_q;
	value_t op_a;
	value_t op_b;

	// ============================================================
	// Execute and result stages
	// ============================================================
	logic ex_v_q;
	thread_id_t ex_thread_q;
	opcode_e ex_op_q;
	reg_num_t ex_rt_q;
	logic [15:0] ex_imm_q;
	value_t ex_a_q;
	value_t ex_b_q;
	value_t alu_res;
	logic res_v_q;
	result_t res_q;

	assign stall_o = result_valid_o && !result_ready_i;
	assign commit_valid_o = result_valid_o && result_ready_i;
	assign result_valid_o = res_v_q;
	assign result_o = res_q;

	// Register file outputs are only good for one cycle after issue
	assign op_a = rd_fresh_q ? a_i : rd_a_q;
	assign op_b = rd_fresh_q ? b_i : rd_b_q;

	int_alu alu_i (
		.op_i(ex_op_q),
		.a_i(ex_a_q),
		.b_i(ex_b_q),
		.imm_i(ex_imm_q),
		.res_o(alu_res)
	);

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			rd_v_q <= 1'b0;
			rd_fresh_q <= 1'b0;
			ex_v_q <= 1'b0;
			res_v_q <= 1'b0;
		end else if (stall_o) begin
			// Everything holds, only the read data is saved
			rd_fresh_q <= 1'b0;
		end else begin
			rd_v_q <= issue_valid_i;
			rd_fresh_q <= issue_valid_i;
			ex_v_q <= rd_v_q;
			res_v_q <= ex_v_q;
		end
	end

	always_ff @(posedge clk_g) begin
		if (stall_o) begin
			if (rd_fresh_q) begin
				rd_a_q <= a_i;
				rd_b_q <= b_i;
			end
		end else begin
			rd_thread_q <= issue_thread_i;
			rd_insn_q <= issue_insn_i;
			ex_thread_q <= rd_thread_q;
			ex_op_q <= rd_insn_q.opcode;
			ex_rt_q <= rd_insn_q.rt;
			ex_imm_q <= rd_insn_q.imm;
			ex_a_q <= op_a;
			ex_b_q <= op_b;
			res_q.thread <= ex_thread_q;
			res_q.rt <= ex_rt_q;
			res_q.value <= alu_res;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mt_core.sv
`default_nettype none

module mt_core
	import mt_core_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk_g,
	input wire rst_i,
	input wire thread_insn_t insn_i,
	input wire insn_valid_i,
	output logic insn_ready_o,
	output result_t result_o,
	output logic result_valid_o,
	input wire result_ready_i
);

	insn_t [NTHREADS-1:0] heads;
	logic [NTHREADS-1:0] head_valid;
	logic [NTHREADS-1:0] full;
	logic [NTHREADS-1:0] push;
	logic [NTHREADS-1:0] pop;
	logic [NTHREADS-1:0] issue_req;
	thread_id_t grant;
	logic grant_valid;
	insn_t issue_insn;
	value_t a_val;
	value_t b_val;
	logic commit_valid;
	logic stall;

	assign insn_ready_o = !full[insn_i.thread];
	assign issue_insn = heads[grant];

	// ============================================================
	// Per-thread instruction queues
	// ============================================================
	for (genvar t = 0; t < NTHREADS; t++) begin : g_queue
		assign push[t] = insn_valid_i && (insn_i.thread == thread_id_t'(t));
		assign pop[t] = grant_valid && (grant == thread_id_t'(t));

		insn_queue #(
			.QUEUE_DEPTH(QUEUE_DEPTH)
		) queue_i (
			.clk_g(clk_g),
			.rst_i(rst_i),
			.push_i(push[t]),
			.push_insn_i(insn_i.insn),
			.pop_i(pop[t]),
			.head_o(heads[t]),
			.head_valid_o(head_valid[t]),
			.full_o(full[t])
		);
	end

	scoreboard sb_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.heads_i(heads),
		.head_valid_i(head_valid),
		.stall_i(stall),
		.issue_valid_i(grant_valid),
		.issue_thread_i(grant),
		.issue_rt_i(issue_insn.rt),
		.commit_valid_i(commit_valid),
		.commit_i(result_o),
		.issue_req_o(issue_req)
	);

	round_robin_select rr_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.req_i(issue_req),
		.grant_o(grant),
		.grant_valid_o(grant_valid)
	);

	// Reads are addressed straight from the granted head
	thread_regfile rf_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.rd_thread_i(grant),
		.ra_i(issue_insn.ra),
		.rb_i(issue_insn.rb),
		.a_o(a_val),
		.b_o(b_val),
		.wr_i(commit_valid),
		.wr_data_i(result_o)
	);

	exec_pipeline pipe_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.issue_valid_i(grant_valid),
		.issue_thread_i(grant),
		.issue_insn_i(issue_insn),
		.a_i(a_val),
		.b_i(b_val),
		.result_o(result_o),
		.result_valid_o(result_valid_o),
		.result_ready_i(result_ready_i),
		.commit_valid_o(commit_valid),
		.stall_o(stall)
	);

endmodule

`default_nettype wire

//--- tests/mt_core_tb.sv
`default_nettype none

module mt_core_tb
	import mt_core_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int QUEUE_DEPTH = 4;
	localparam logic [31:0] SEED = 32'hf8db9a46;
	localparam int N_RESET = 16;
	localparam int N_RANDOM = 300;
	localparam int N_CHAIN = 8 * NTHREADS;
	localparam int N_ZERO = 4 * NTHREADS;
	localparam int N_BACKPRESSURE = 200;
	localparam int N_PROGRESS = 200;
	localparam int N_TOTAL = N_RESET + N_RANDOM + N_CHAIN + N_ZERO + N_BACKPRESSURE + N_PROGRESS;
	localparam int TIMEOUT_CYCLES = N_TOTAL * NTHREADS * 20;

	logic clk_g = 1'b0;
	logic rst_i;
	thread_insn_t insn_i;
	logic insn_valid_i;
	logic insn_ready_o;
	result_t result_o;
	logic result_valid_o;
	logic result_ready_i;

	// Reference model state, one register set and one result queue per thread
	value_t model_regs [NTHREADS][NREGS];
	result_t expected_q [NTHREADS][$];

	logic [31:0] stim_state;
	logic [31:0] ready_state;
	logic bp_mode;
	int error_count;
	int result_count;

	mt_core #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) mt_core_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.insn_i(insn_i),
		.insn_valid_i(insn_valid_i),
		.insn_ready_o(insn_ready_o),
		.result_o(result_o),
		.result_valid_o(result_valid_o),
		.result_ready_i(result_ready_i)
	);

	always #(CLK_PERIOD / 2) clk_g = ~clk_g;

	// ============================================================
	// Random numbers and the reference model
	// ============================================================

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_stim();
		stim_state = lcg_step(stim_state);
		return stim_state;
	endfunction

	function automatic value_t model_alu(input opcode_e op, input value_t a, input value_t b,
			input logic [15:0] imm);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND_OP: return a & b;
			OR_OP: return a | b;
			XOR_OP: return a ^ b;
			SHL: return a << b[4:0];
			SHR: return a >> b[4:0];
			ADDI: return a + {{16{imm[15]}}, imm};
			default: return '0;
		endcase
	endfunction

	// Registers are drawn from r0 up to nregs_used-1
	function automatic insn_t random_insn(input int nregs_used);
		insn_t insn;
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = next_stim();
		r2 = next_stim();
		insn.opcode = opcode_e'(r1[31:29]);
		insn.rt = reg_num_t'(int'(r1[27:24]) % nregs_used);
		insn.ra = reg_num_t'(int'(r1[23:20]) % nregs_used);
		insn.rb = reg_num_t'(int'(r1[19:16]) % nregs_used);
		insn.imm = r2[31:16];
		return insn;
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int t = 0; t < NTHREADS; t++)
			n += expected_q[t].size();
		return n;
	endfunction

	task automatic check_result(input result_t exp, input result_t act);
		if (act !== exp) begin
			$display("error result_o expected %h got %h", exp, act);
			error_count++;
		end
	endtask

	task automatic check_ready(input logic exp, input logic act);
		if (act !== exp) begin
			$display("error insn_ready_o expected %h got %h", exp, act);
			error_count++;
		end
	endtask

	// With every queue drained the core takes an instruction for any thread
	task automatic check_all_ready();
		for (int t = 0; t < NTHREADS; t++) begin
			insn_i.thread = thread_id_t'(t);
			#1;
			check_ready(1'b1, insn_ready_o);
		end
	endtask

	// ============================================================
	// Instruction driver
	// ============================================================

	// Holds the instruction until the core takes it, then updates the model
	task automatic send_insn(input thread_id_t th, input insn_t insn);
		result_t exp;
		logic accepted;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk_g);
			insn_i.thread = th;
			insn_i.insn = insn;
			insn_valid_i = 1'b1;
			#1;
			accepted = insn_ready_o;
			// Every queued instruction still owes a result
			if (!accepted && expected_q[th].size() < QUEUE_DEPTH) begin
				$display("thread %0d refused an instruction with only %0d outstanding",
					th, expected_q[th].size());
				error_count++;
			end
		end
		exp.thread = th;
		exp.rt = insn.rt;
		exp.value = model_alu(insn.opcode, model_regs[th][insn.ra], model_regs[th][insn.rb],
			insn.imm);
		if (insn.rt != '0)
			model_regs[th][insn.rt] = exp.value;
		expected_q[th].push_back(exp);
		@(posedge clk_g);
	endtask

	task automatic finish_test(input string name, input int n_insn, input int errors_before);
		@(negedge clk_g);
		insn_valid_i = 1'b0;
		while (outstanding() != 0)
			@(negedge clk_g);
		// A few idle cycles so a stray extra result would still be seen
		repeat (4) @(negedge clk_g);
		check_all_ready();
		$display("%s: %0d instructions, %0d errors", name, n_insn, error_count - errors_before);
	endtask

	// ============================================================
	// Result monitor
	// ============================================================

	initial begin : result_monitor
		result_t held;
		result_t exp;
		logic waiting;
		waiting = 1'b0;
		held = '0;
		forever begin
			@(negedge clk_g);
			if (waiting) begin
				if (!result_valid_o) begin
					$display("result valid dropped before the result was taken");
					error_count++;
				end else begin
					check_result(held, result_o);
				end
			end
			ready_state = lcg_step(ready_state);
			result_ready_i = bp_mode ? ready_state[31] : 1'b1;
			if (result_valid_o && result_ready_i) begin
				result_count++;
				if (expected_q[result_o.thread].size() == 0) begin
					$display("result for thread %0d arrived with no instruction outstanding",
						result_o.thread);
					error_count++;
				end else begin
					exp = expected_q[result_o.thread].pop_front();
					check_result(exp, result_o);
				end
			end
			waiting = result_valid_o && !result_ready_i;
			held = result_o;
		end
	end

	initial begin : watchdog
		int missing;
		missing = 0;
		repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk_g);
		$display("timeout after %0d cycles", RESET_CYCLES + TIMEOUT_CYCLES);
		for (int t = 0; t < NTHREADS; t++) begin
			if (expected_q[t].size() != 0) begin
				$display("thread %0d still waits for %0d results", t, expected_q[t].size());
				missing++;
			end
		end
		if (missing == 0)
			$display("no thread had results missing, the test sequence itself stalled");
		$display("Simulation failed");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		insn_t insn;
		thread_id_t th;
		logic [31:0] r;
		int errs;
		rst_i = 1'b1;
		insn_i = '0;
		insn_valid_i = 1'b0;
		result_ready_i = 1'b1;
		bp_mode = 1'b0;
		stim_state = SEED;
		ready_state = lcg_step(~SEED);
		error_count = 0;
		result_count = 0;
		for (int t = 0; t < NTHREADS; t++)
			for (int i = 0; i < NREGS; i++)
				model_regs[t][i] = '0;
		repeat (RESET_CYCLES) @(posedge clk_g);
		@(negedge clk_g);
		rst_i = 1'b0;

		// Every register starts at zero, so all sums are zero
		errs = error_count;
		check_all_ready();
		for (int i = 0; i < N_RESET; i++) begin
			insn = random_insn(NREGS);
			insn.opcode = ADD;
			send_insn(thread_id_t'(i % NTHREADS), insn);
		end
		finish_test("reset_state", N_RESET, errs);

		errs = error_count;
		for (int i = 0; i < N_RANDOM; i++) begin
			r = next_stim();
			send_insn(thread_id_t'(r[31:30]), random_insn(NREGS));
		end
		finish_test("random_ops", N_RANDOM, errs);

		// Each step reads the register written by the step before, back to back in one thread
		errs = error_count;
		for (int t = 0; t < NTHREADS; t++) begin
			for (int s = 0; s < N_CHAIN / NTHREADS; s++) begin
				r = next_stim();
				insn.opcode = (s % 2 == 0) ? ADDI : ADD;
				insn.rt = reg_num_t'(s + 1);
				insn.ra = reg_num_t'(s);
				insn.rb = reg_num_t'(s);
				insn.imm = r[31:16];
				send_insn(thread_id_t'(t), insn);
			end
		end
		finish_test("dependencies", N_CHAIN, errs);

		errs = error_count;
		for (int t = 0; t < NTHREADS; t++) begin
			th = thread_id_t'(t);
			r = next_stim();
			send_insn(th, '{opcode: ADDI, rt: 4'd0, ra: 4'd1, rb: 4'd0, imm: r[31:16]});
			send_insn(th, '{opcode: ADD, rt: 4'd5, ra: 4'd0, rb: 4'd0, imm: 16'h0});
			send_insn(th, '{opcode: OR_OP, rt: 4'd6, ra: 4'd0, rb: 4'd0, imm: 16'h0});
			send_insn(th, '{opcode: ADDI, rt: 4'd7, ra: 4'd0, rb: 4'd0, imm: r[15:0]});
		end
		finish_test("register_zero", N_ZERO, errs);

		errs = error_count;
		bp_mode = 1'b1;
		for (int i = 0; i < N_BACKPRESSURE; i++) begin
			r = next_stim();
			send_insn(thread_id_t'(r[31:30]), random_insn(NREGS));
		end
		finish_test("back_pressure", N_BACKPRESSURE, errs);

		// Few registers and slow draining keep every queue full
		errs = error_count;
		for (int i = 0; i < N_PROGRESS; i++)
			send_insn(thread_id_t'(i % NTHREADS), random_insn(3));
		finish_test("thread_progress", N_PROGRESS, errs);

		$display("results checked %0d, errors %0d", result_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mt_core_pkg.sv
rtl/insn_queue.sv
rtl/round_robin_select.sv
rtl/scoreboard.sv
rtl/thread_regfile.sv
rtl/int_alu.sv
rtl/exec_pipeline.sv
rtl/mt_core.sv
tests/mt_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mt_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module mt_core_tb -o mt_core_sim

sim_out=$(./obj_dir/mt_core_sim)
echo "$sim_out"

# Pass only if the testbench printed its pass line
echo "$sim_out" | grep -qx "Simulation passed"
